//--- filelist.f
+incdir+design
design/decode_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/stage_latch.sv
design/decode_top.sv
verif/clk_gen.sv
verif/decode_props.sv
verif/decode_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module decode_tb -o decode_sim

status=0
./obj_dir/decode_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test completed successfully" sim.log && [ "$status" -eq 0 ]; then
  exit 0
fi
exit 1

//--- verif/decode_tb.sv
`include "decode_defines.svh"

module decode_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TD    = `TRACK_DEPTH;
  localparam int NROWS = 18;
  localparam int LIMIT = NROWS * (TD + 2) + 20;

  typedef struct {
    logic [31:0]           inst;
    logic [`DBITS-1:0]     pc;
    logic                  flush;
    logic [`DBITS-1:0]     wb;
    decode_pkg::op_t       op;
    logic [`DBITS-1:0]     imm;
    decode_pkg::dest_tag_t tag;
    logic                  stall;
  } row_t;

  logic clk, reset, fe_valid, br_flush, fe_stall, de_valid, de_wr_reg, de_is_branch;
  logic [31:0] fe_inst;
  logic [`DBITS-1:0] fe_pc, wb_value, de_pc, de_rs1_val, de_rs2_val, de_imm;
  logic [`REGNOBITS-1:0] de_rd;
  decode_pkg::op_t de_op;

  row_t rows [NROWS];
  logic [`DBITS-1:0] regs [`REGWORDS]; // reference register model
  decode_pkg::dest_tag_t ptag [TD+1];   // [0] is the decode latch
  logic [`DBITS-1:0] pval [TD+1];
  decode_pkg::de_bundle_t exp_q;
  int errors, cycles, seed;

  clk_gen u_clk (.clk(clk), .reset(reset));

  decode_top uut (
    .clk(clk), .reset(reset), .fe_valid(fe_valid), .fe_inst(fe_inst), .fe_pc(fe_pc),
    .br_flush(br_flush), .wb_value(wb_value), .fe_stall(fe_stall), .de_valid(de_valid),
    .de_op(de_op), .de_pc(de_pc), .de_rs1_val(de_rs1_val), .de_rs2_val(de_rs2_val),
    .de_imm(de_imm), .de_rd(de_rd), .de_wr_reg(de_wr_reg), .de_is_branch(de_is_branch)
  );

  task automatic add_row(int i, logic [31:0] inst, logic flush, logic [`DBITS-1:0] wb,
                         decode_pkg::op_t op, logic [`DBITS-1:0] imm,
                         logic [`REGNOBITS-1:0] rd, logic wr, logic stall);
    rows[i] = '{inst, 32'h100 + 32'(4 * i), flush, wb, op, imm, '{wr_reg: wr, rd: rd}, stall};
  endtask

  task automatic check_op(string name, decode_pkg::op_t got, decode_pkg::op_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_data(string name, logic [`DBITS-1:0] got, logic [`DBITS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("error %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_tag(string name, decode_pkg::dest_tag_t got,
                           decode_pkg::dest_tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %s got %h exp %h", name, got, exp);
    end
  endtask

  // read-after-write against the decode latch and all but the last slot
  function automatic logic hazard_exp(logic [31:0] inst, decode_pkg::op_t op);
    logic u1;
    logic u2;
    u1 = !(op inside {decode_pkg::OP_INVALID, decode_pkg::OP_LUI, decode_pkg::OP_AUIPC,
                      decode_pkg::OP_JAL});
    u2 = op inside {[decode_pkg::OP_ADD:decode_pkg::OP_MUL], decode_pkg::OP_SW,
                    [decode_pkg::OP_BEQ:decode_pkg::OP_BGEU]};
    for (int k = 0; k < TD; k++) begin
      if (ptag[k].wr_reg && ((u1 && ptag[k].rd == inst[19:15]) ||
                             (u2 && ptag[k].rd == inst[24:20]))) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [`DBITS-1:0] read_model(logic [`REGNOBITS-1:0] idx);
    if (ptag[TD].wr_reg && ptag[TD].rd == idx) return pval[TD];
    return regs[idx];
  endfunction

  always @(posedge clk) begin
    if (!reset) cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: no finish after %0d cycles", LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int i, exp_row, row_err0, r;
    logic acc, have_exp, seen_stall, st, exp_bubble;
    logic [31:0] rnd;
    fe_valid = 0;
    fe_inst  = '0;
    fe_pc    = '0;
    br_flush = 0;
    wb_value = '0;
    errors = 0;
    cycles = 0;
    seed   = 98;
    foreach (regs[k]) regs[k] = '0;
    foreach (ptag[k]) begin
      ptag[k] = '0;
      pval[k] = '0;
    end
    add_row(0, {12'hffb, 5'd0, 3'b000, 5'd1, 7'h13}, 0, 32'h11110001,
            decode_pkg::OP_ADDI, 32'hfffffffb, 1, 1, 0);
    add_row(1, {20'habcde, 5'd2, 7'h37}, 0, 32'h22220002,
            decode_pkg::OP_LUI, 32'habcde000, 2, 1, 0);
    add_row(2, {7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33}, 0, 32'h33330003,
            decode_pkg::OP_ADD, 0, 3, 1, 1);
    add_row(3, {7'h00, 5'd3, 5'd1, 3'b010, 5'd8, 7'h23}, 0, 0,
            decode_pkg::OP_SW, 8, 8, 0, 1);
    add_row(4, {7'h7f, 5'd0, 5'd0, 3'b000, 5'h1d, 7'h63}, 0, 0,
            decode_pkg::OP_BEQ, 32'hfffffffc, 29, 0, 0);
    add_row(5, {1'b0, 10'd0, 1'b1, 8'd0, 5'd5, 7'h6f}, 0, 32'h55550005,
            decode_pkg::OP_JAL, 32'h800, 5, 1, 0);
    add_row(6, {12'd7, 5'd0, 3'b000, 5'd0, 7'h13}, 0, 32'h66660006,
            decode_pkg::OP_ADDI, 7, 0, 0, 0); // x0 destination
    add_row(7, {7'h00, 5'd2, 5'd1, 3'b100, 5'd6, 7'h33}, 1, 32'h77770007,
            decode_pkg::OP_XOR, 0, 6, 1, 0); // flushed
    add_row(8, {7'h01, 5'd1, 5'd5, 3'b000, 5'd7, 7'h33}, 0, 32'h88880008,
            decode_pkg::OP_MUL, 0, 7, 1, 1);
    add_row(9, 32'hffffffff, 0, 0, decode_pkg::OP_INVALID, 0, 31, 0, 0);
    add_row(10, {7'h20, 5'd3, 5'd7, 3'b101, 5'd8, 7'h13}, 0, 32'h9999000a,
            decode_pkg::OP_SRAI, 32'h403, 8, 1, 1);
    add_row(11, {12'hff0, 5'd8, 3'b010, 5'd9, 7'h03}, 0, 32'haaaa000b,
            decode_pkg::OP_LW, 32'hfffffff0, 9, 1, 1);
    add_row(12, {20'h80000, 5'd10, 7'h17}, 0, 32'hbbbb000c,
            decode_pkg::OP_AUIPC, 32'h80000000, 10, 1, 0);
    for (int f = 13; f < 17; f++) begin
      rnd = $random(seed); // random addi filler into x16..x31
      add_row(f, {rnd[31:20], 5'd0, 3'b000, 1'b1, rnd[3:0], 7'h13}, 0, $random(seed),
              decode_pkg::OP_ADDI, {{20{rnd[31]}}, rnd[31:20]}, {1'b1, rnd[3:0]}, 1, 0);
    end
    add_row(17, {7'h00, 5'd10, 5'd9, 3'b000, 5'd11, 7'h33}, 0, 32'hcccc0011,
            decode_pkg::OP_ADD, 0, 11, 1, 0);

    @(negedge clk);
    while (reset) @(negedge clk);
    check_bit("de_valid", de_valid, 1'b0);
    check_bit("de_wr_reg", de_wr_reg, 1'b0);
    check_bit("fe_stall", fe_stall, 1'b0);

    i          = 0;
    acc        = 0;
    have_exp   = 0;
    exp_bubble = 0;
    seen_stall = 0;
    exp_row    = 0;
    row_err0   = errors;
    while (i < NROWS || have_exp) begin
      @(posedge clk);
      if (ptag[TD].wr_reg) regs[ptag[TD].rd] = pval[TD];
      for (int k = TD; k > 0; k--) begin
        ptag[k] = ptag[k-1];
        pval[k] = pval[k-1];
      end
      ptag[0] = acc ? rows[exp_row].tag : '0;
      pval[0] = acc ? rows[exp_row].wb : '0;
      fe_valid <= (i < NROWS);
      r = (i < NROWS) ? i : NROWS - 1;
      fe_inst  <= rows[r].inst;
      fe_pc    <= rows[r].pc;
      br_flush <= (i < NROWS) && rows[r].flush;
      wb_value <= pval[TD];
      @(negedge clk);
      acc = 0;
      if (exp_bubble) begin
        check_bit("de_valid", de_valid, 1'b0); // stalled row leaves a bubble
        check_bit("de_wr_reg", de_wr_reg, 1'b0);
        exp_bubble = 0;
      end
      if (have_exp) begin
        check_bit("de_valid", de_valid, exp_q.valid);
        check_op("de_op", de_op, exp_q.op);
        check_data("de_pc", de_pc, exp_q.pc);
        check_data("de_rs1_val", de_rs1_val, exp_q.rs1_val);
        check_data("de_rs2_val", de_rs2_val, exp_q.rs2_val);
        check_data("de_imm", de_imm, exp_q.imm);
        check_tag("de_rd/de_wr_reg", decode_pkg::dest_tag_t'{wr_reg: de_wr_reg, rd: de_rd},
                  exp_q.dest);
        check_bit("de_is_branch", de_is_branch, exp_q.is_branch);
        $display("row %0d %s", exp_row, (errors == row_err0) ? "ok" : "mismatch");
        have_exp = 0;
        row_err0 = errors;
      end
      if (i < NROWS) begin
        st = hazard_exp(rows[i].inst, rows[i].op);
        check_bit("fe_stall", fe_stall, st);
        if (st) begin
          seen_stall = 1;
          exp_bubble = 1;
        end else begin
          if (seen_stall != rows[i].stall) begin
            errors++;
            $display("row %0d stall flag %0d does not match the table", i, seen_stall);
          end
          exp_q = '0;
          if (!rows[i].flush) begin
            exp_q = '{1'b1, rows[i].pc, rows[i].op, read_model(rows[i].inst[19:15]),
                      read_model(rows[i].inst[24:20]), rows[i].imm, rows[i].tag,
                      rows[i].op inside {[decode_pkg::OP_BEQ:decode_pkg::OP_BGEU]}};
          end
          acc = !rows[i].flush;
          exp_row = i;
          have_exp = 1;
          seen_stall = 0;
          i++;
        end
      end
    end

    $display("rows %0d, errors %0d", NROWS, errors);
    if (errors == 0) $display("Test completed successfully");
    else $display("Test failed");
    $finish;
  end
endmodule

//--- verif/decode_props.sv
`include "decode_defines.svh"

module decode_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  fe_valid,
  input logic [31:0]           fe_inst,
  input logic                  fe_stall,
  input logic                  br_flush,
  input logic                  de_valid,
  input logic                  de_wr_reg,
  input logic [`REGNOBITS-1:0] de_rd
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stall or a flush leaves an empty decode latch behind
  a_bubble: assert property (@(posedge clk) disable iff (reset)
    (fe_stall || br_flush) |=> !de_valid)
    else $error("decode latch not empty after stall or flush");

  // fetch keeps a stalled instruction valid and unchanged
  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    fe_stall |=> fe_valid && $stable(fe_inst))
    else $error("fetch dropped or changed a stalled instruction");

  a_no_x0: assert property (@(posedge clk) disable iff (reset) de_wr_reg |-> de_rd != '0)
    else $error("register write tagged for x0");
endmodule

bind decode_top decode_props u_props (
  .clk       (clk),
  .reset     (reset),
  .fe_valid  (fe_valid),
  .fe_inst   (fe_inst),
  .fe_stall  (fe_stall),
  .br_flush  (br_flush),
  .de_valid  (de_valid),
  .de_wr_reg (de_wr_reg),
  .de_rd     (de_rd)
);

//--- verif/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;
  always #5 clk = ~clk; // 10 ns period

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end
endmodule

//--- design/decode_top.sv
`include "decode_defines.svh"

module decode_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fe_valid,
  input  logic [31:0]           fe_inst,
  input  logic [`DBITS-1:0]     fe_pc,
  input  logic                  br_flush,
  input  logic [`DBITS-1:0]     wb_value,
  output logic                  fe_stall,
  output logic                  de_valid,
  output decode_pkg::op_t       de_op,
  output logic [`DBITS-1:0]     de_pc,
  output logic [`DBITS-1:0]     de_rs1_val,
  output logic [`DBITS-1:0]     de_rs2_val,
  output logic [`DBITS-1:0]     de_imm,
  output logic [`REGNOBITS-1:0] de_rd,
  output logic                  de_wr_reg,
  output logic                  de_is_branch
);

  decode_pkg::op_t       op;
  logic [`DBITS-1:0]     imm;
  logic [`REGNOBITS-1:0] rs1;
  logic [`REGNOBITS-1:0] rs2;
  logic                  rs1_used;
  logic                  rs2_used;
  decode_pkg::dest_tag_t dest;
  logic                  is_branch;
  logic [`DBITS-1:0]     rs1_val;
  logic [`DBITS-1:0]     rs2_val;
  logic                  hazard;
  logic                  de_bubble;
  decode_pkg::de_bundle_t de_d;
  decode_pkg::de_bundle_t de_q;

  decode_pkg::dest_tag_t                   chain [`TRACK_DEPTH+1]; // [0] is the decode latch tag
  decode_pkg::dest_tag_t [`TRACK_DEPTH-1:0] inflight;

  inst_decoder u_dec (
    .inst      (fe_inst),
    .op        (op),
    .imm       (imm),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_used  (rs1_used),
    .rs2_used  (rs2_used),
    .dest      (dest),
    .is_branch (is_branch)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr_en   (chain[`TRACK_DEPTH].wr_reg),
    .wr_idx  (chain[`TRACK_DEPTH].rd),
    .wr_data (wb_value)
  );

  always_comb begin
    for (int i = 0; i < `TRACK_DEPTH; i++) begin
      inflight[i] = chain[i];
    end
  end

  hazard_unit u_haz (
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used),
    .inflight (inflight),
    .hazard   (hazard)
  );

  assign fe_stall  = fe_valid && hazard;
  assign de_bubble = fe_stall || br_flush || !fe_valid; // flush does not stall fetch

  always_comb begin
    de_d.valid     = fe_valid;
    de_d.pc        = fe_pc;
    de_d.op        = op;
    de_d.rs1_val   = rs1_val;
    de_d.rs2_val   = rs2_val;
    de_d.imm       = imm;
    de_d.dest      = dest;
    de_d.is_branch = is_branch;
  end

  stage_latch #(.payload_t(decode_pkg::de_bundle_t)) u_de_latch (
    .clk    (clk),
    .reset  (reset),
    .bubble (de_bubble),
    .d      (de_d),
    .q      (de_q)
  );

  assign chain[0] = de_q.dest;

  // execute, memory and writeback tags, no back-pressure
  generate
    for (genvar i = 0; i < `TRACK_DEPTH; i++) begin : g_track
      stage_latch #(.payload_t(decode_pkg::dest_tag_t)) u_slot (
        .clk    (clk),
        .reset  (reset),
        .bubble (1'b0),
        .d      (chain[i]),
        .q      (chain[i+1])
      );
    end
  endgenerate

  assign de_valid     = de_q.valid;
  assign de_op        = de_q.op;
  assign de_pc        = de_q.pc;
  assign de_rs1_val   = de_q.rs1_val;
  assign de_rs2_val   = de_q.rs2_val;
  assign de_imm       = de_q.imm;
  assign de_rd        = de_q.dest.rd;
  assign de_wr_reg    = de_q.dest.wr_reg;
  assign de_is_branch = de_q.is_branch;

endmodule

//--- design/stage_latch.sv
module stage_latch #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      q <= '0; // empty slot
    end else begin
      q <= d;
    end
  end

endmodule

//--- design/hazard_unit.sv
`include "decode_defines.svh"

module hazard_unit (
  input  logic [`REGNOBITS-1:0]                     rs1,
  input  logic [`REGNOBITS-1:0]                     rs2,
  input  logic                                      rs1_used,
  input  logic                                      rs2_used,
  input  decode_pkg::dest_tag_t [`TRACK_DEPTH-1:0]  inflight,
  output logic                                      hazard
);

  // the last tracking slot is left out, its write is already visible
  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < `TRACK_DEPTH; i++) begin
      if (inflight[i].wr_reg &&
          ((rs1_used && inflight[i].rd == rs1) ||
           (rs2_used && inflight[i].rd == rs2))) begin
        hazard = 1'b1;
      end
    end
  end

endmodule

//--- design/reg_file.sv
`include "decode_defines.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`REGNOBITS-1:0] rs1,
  input  logic [`REGNOBITS-1:0] rs2,
  output logic [`DBITS-1:0]     rs1_val,
  output logic [`DBITS-1:0]     rs2_val,
  input  logic                  wr_en,
  input  logic [`REGNOBITS-1:0] wr_idx,
  input  logic [`DBITS-1:0]     wr_data
);

  logic [`DBITS-1:0] regs [`REGWORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REGWORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through lets a reader see the retiring value in the same cycle
  assign rs1_val = (wr_en && wr_idx == rs1) ? wr_data : regs[rs1];
  assign rs2_val = (wr_en && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

//--- design/inst_decoder.sv
`include "decode_defines.svh"

module inst_decoder (
  input  logic [31:0]           inst,
  output decode_pkg::op_t       op,
  output logic [`DBITS-1:0]     imm,
  output logic [`REGNOBITS-1:0] rs1,
  output logic [`REGNOBITS-1:0] rs2,
  output logic                  rs1_used,
  output logic                  rs2_used,
  output decode_pkg::dest_tag_t dest,
  output logic                  is_branch
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0]            opcode;
  logic [2:0]            f3;
  logic [6:0]            f7;
  logic [`REGNOBITS-1:0] rd;
  decode_pkg::fmt_t      fmt;
  decode_pkg::imm_t      imm_kind;
  logic                  writes;

  assign opcode = inst[6:0];
  assign f3     = inst[14:12];
  assign f7     = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  always_comb begin
    op = decode_pkg::OP_INVALID;
    case (opcode)
      OPC_OP: begin
        case ({f7, f3}) // funct7 and funct3 together
          10'b0000000_000: op = decode_pkg::OP_ADD;
          10'b0100000_000: op = decode_pkg::OP_SUB;
          10'b0000000_001: op = decode_pkg::OP_SLL;
          10'b0000000_010: op = decode_pkg::OP_SLT;
          10'b0000000_011: op = decode_pkg::OP_SLTU;
          10'b0000000_100: op = decode_pkg::OP_XOR;
          10'b0000000_101: op = decode_pkg::OP_SRL;
          10'b0100000_101: op = decode_pkg::OP_SRA;
          10'b0000000_110: op = decode_pkg::OP_OR;
          10'b0000000_111: op = decode_pkg::OP_AND;
          10'b0000001_000: op = decode_pkg::OP_MUL;
          default: op = decode_pkg::OP_INVALID;
        endcase
      end
      OPC_OP_IMM: begin
        case (f3)
          3'b000: op = decode_pkg::OP_ADDI;
          3'b010: op = decode_pkg::OP_SLTI;
          3'b011: op = decode_pkg::OP_SLTIU;
          3'b100: op = decode_pkg::OP_XORI;
          3'b110: op = decode_pkg::OP_ORI;
          3'b111: op = decode_pkg::OP_ANDI;
          3'b001: if (f7 == 7'b0000000) op = decode_pkg::OP_SLLI;
          3'b101: begin
            if (f7 == 7'b0000000) op = decode_pkg::OP_SRLI;
            else if (f7 == 7'b0100000) op = decode_pkg::OP_SRAI;
          end
          default: op = decode_pkg::OP_INVALID;
        endcase
      end
      OPC_LUI:   op = decode_pkg::OP_LUI;
      OPC_AUIPC: op = decode_pkg::OP_AUIPC;
      OPC_JAL:   op = decode_pkg::OP_JAL;
      OPC_LOAD:  if (f3 == 3'b010) op = decode_pkg::OP_LW;
      OPC_STORE: if (f3 == 3'b010) op = decode_pkg::OP_SW;
      OPC_JALR:  if (f3 == 3'b000) op = decode_pkg::OP_JALR;
      OPC_BRANCH: begin
        case (f3)
          3'b000: op = decode_pkg::OP_BEQ;
          3'b001: op = decode_pkg::OP_BNE;
          3'b100: op = decode_pkg::OP_BLT;
          3'b101: op = decode_pkg::OP_BGE;
          3'b110: op = decode_pkg::OP_BLTU;
          3'b111: op = decode_pkg::OP_BGEU;
          default: op = decode_pkg::OP_INVALID;
        endcase
      end
      default: op = decode_pkg::OP_INVALID;
    endcase
  end

  // format, immediate kind and register write follow from op alone
  always_comb begin
    fmt      = decode_pkg::FMT_NONE;
    imm_kind = decode_pkg::IMM_NONE;
    writes   = 1'b1;
    case (op)
      decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_AND, decode_pkg::OP_OR,
      decode_pkg::OP_XOR, decode_pkg::OP_SLT, decode_pkg::OP_SLTU, decode_pkg::OP_SRA,
      decode_pkg::OP_SRL, decode_pkg::OP_SLL, decode_pkg::OP_MUL: begin
        fmt = decode_pkg::FMT_R;
      end
      decode_pkg::OP_ADDI, decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI,
      decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU, decode_pkg::OP_SRAI, decode_pkg::OP_SRLI,
      decode_pkg::OP_SLLI, decode_pkg::OP_LW, decode_pkg::OP_JALR: begin
        fmt      = decode_pkg::FMT_I;
        imm_kind = decode_pkg::IMM_I;
      end
      decode_pkg::OP_LUI, decode_pkg::OP_AUIPC: begin
        fmt      = decode_pkg::FMT_U;
        imm_kind = decode_pkg::IMM_U;
      end
      decode_pkg::OP_JAL: begin
        fmt      = decode_pkg::FMT_J;
        imm_kind = decode_pkg::IMM_J;
      end
      decode_pkg::OP_SW: begin
        fmt      = decode_pkg::FMT_S;
        imm_kind = decode_pkg::IMM_S;
        writes   = 1'b0;
      end
      decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_BLT,
      decode_pkg::OP_BGE, decode_pkg::OP_BLTU, decode_pkg::OP_BGEU: begin
        fmt      = decode_pkg::FMT_B;
        imm_kind = decode_pkg::IMM_B;
        writes   = 1'b0;
      end
      default: writes = 1'b0; // invalid encoding
    endcase
  end

  always_comb begin
    case (imm_kind)
      decode_pkg::IMM_I: imm = {{(`DBITS-12){inst[31]}}, inst[31:20]};
      decode_pkg::IMM_S: imm = {{(`DBITS-12){inst[31]}}, inst[31:25], inst[11:7]};
      decode_pkg::IMM_B: imm = {{(`DBITS-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      decode_pkg::IMM_U: imm = {inst[31:12], 12'b0};
      decode_pkg::IMM_J: imm = {{(`DBITS-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:           imm = '0;
    endcase
  end

  assign rs1_used  = fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_I,
                                 decode_pkg::FMT_S, decode_pkg::FMT_B};
  assign rs2_used  = fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_S, decode_pkg::FMT_B};
  assign is_branch = (fmt == decode_pkg::FMT_B);

  // x0 never counts as a destination
  assign dest = '{wr_reg: writes && (rd != '0), rd: rd};

endmodule

//--- design/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

  // OP_INVALID sits at zero so a bubble carries no real operation
  typedef enum logic [5:0] {
    OP_INVALID,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
    OP_SRA, OP_SRL, OP_SLL, OP_MUL,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU,
    OP_SRAI, OP_SRLI, OP_SLLI,
    OP_LUI, OP_AUIPC,
    OP_LW, OP_SW,
    OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
  } op_t;

  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
  } fmt_t;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_t;

  typedef struct packed {
    logic                  wr_reg;
    logic [`REGNOBITS-1:0] rd;
  } dest_tag_t;

  typedef struct packed {
    logic              valid;
    logic [`DBITS-1:0] pc;
    op_t               op;
    logic [`DBITS-1:0] rs1_val;
    logic [`DBITS-1:0] rs2_val;
    logic [`DBITS-1:0] imm;
    dest_tag_t         dest;
    logic              is_branch;
  } de_bundle_t;

endpackage

//--- design/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// data path and pc width
`define DBITS 32

// architectural registers
`define REGWORDS 32
`define REGNOBITS 5

// tracking latches behind the decode latch (execute, memory, writeback)
`define TRACK_DEPTH 3

`endif
